// ==== pc_settings.svh ====
// PC unit build constants: address width, call field, return stack depth, reset vector
`ifndef PC_SETTINGS_SVH
`define PC_SETTINGS_SVH

// Program counter width
// Byte addressed with two-byte instructions, so bit 0 stays clear
`define PC_WIDTH 16

// Absolute call field carried in the instruction
// Upper PC_WIDTH - CALL_FIELD_WIDTH bits come from the current PC (4 KB page)
`define CALL_FIELD_WIDTH 12

// Return address stack entries
// Power of two, the count register is one bit wider than the index
`define RAS_DEPTH 8

// First fetch address after reset
// Also where a return lands when the stack holds nothing
`define RESET_VECTOR 16'h0000

`endif

// ==== pc_pkg.sv ====
// Shared types for the next-PC unit: branch conditions, ALU flags, request and redirect
`include "pc_settings.svh"

package pc_pkg;

    // Branch condition field of the instruction
    typedef enum logic [2:0] {
        EQ     = 3'b000,
        LT     = 3'b001,
        GT     = 3'b010,
        OV     = 3'b011,
        NE     = 3'b100,
        GE     = 3'b101,
        LE     = 3'b110,
        ALWAYS = 3'b111
    } branch_cond_e;

    // ALU status, meaningful only while alu_done is high
    typedef struct packed {
        logic z;  // Result zero
        logic v;  // Signed overflow
        logic n;  // Result negative
    } alu_flags_t;

    // Control-flow fields of the instruction in execute
    typedef struct packed {
        logic                         branch;
        branch_cond_e                 cond;
        logic signed [`PC_WIDTH-1:0]  offset;       // Byte displacement from pc + 2
        logic                         call;
        logic [`CALL_FIELD_WIDTH-1:0] call_target;  // Low bits of the callee
        logic                         ret;
    } pc_req_t;

    // Decision handed from the resolver to the sequencer
    typedef struct packed {
        logic [`PC_WIDTH-1:0] target;    // Next PC when taken
        logic                 taken;
        logic                 wait_alu;  // Branch present, flags not ready
        logic                 push;      // Call resolving
        logic                 pop;       // Return resolving
    } pc_redirect_t;

endpackage

// ==== pc_update.sv ====
// Next-PC resolver turning the branch, call or return in execute into a redirect
`timescale 1ns/100ps
`include "pc_settings.svh"

module pc_update import pc_pkg::*; (
    input  logic [`PC_WIDTH-1:0] pc,
    input  pc_req_t              req,
    input  alu_flags_t           flags,
    input  logic                 alu_done,
    input  logic [`PC_WIDTH-1:0] ras_top,
    input  logic                 ras_empty,
    output pc_redirect_t         redir
);

    localparam logic [`PC_WIDTH-1:0] INSN_BYTES = 2;

    logic [`PC_WIDTH-1:0] seq_pc;      // Fall-through address
    logic [`PC_WIDTH-1:0] br_target;
    logic [`PC_WIDTH-1:0] call_addr;
    logic [`PC_WIDTH-1:0] ret_target;
    logic                 cond_met;

    assign seq_pc    = pc + INSN_BYTES;
    assign br_target = seq_pc + req.offset;  // Wraps modulo 2^PC_WIDTH

    // Callee stays in the current page
    assign call_addr = {pc[`PC_WIDTH-1:`CALL_FIELD_WIDTH], req.call_target};

    // Empty stack sends a stray return back to the reset vector
    assign ret_target = ras_empty ? `RESET_VECTOR : ras_top;

    // Condition test against Z, V, N
    always_comb begin
        case (req.cond)
            EQ: begin
                cond_met = flags.z;
            end
            LT: begin
                cond_met = flags.n & ~flags.v;
            end
            GT: begin
                cond_met = ~flags.n & ~flags.v & ~flags.z;
            end
            OV: begin
                cond_met = flags.v;
            end
            NE: begin
                cond_met = ~flags.z;
            end
            GE: begin
                cond_met = flags.v | ~flags.n;
            end
            LE: begin
                cond_met = flags.z | (flags.n & ~flags.v);
            end
            ALWAYS: begin
                cond_met = 1'b1;
            end
            default: begin
                cond_met = 1'b0;  // Unknown encoding never redirects
            end
        endcase
    end

    // Priority is branch, call, return
    always_comb begin
        redir        = '0;
        redir.target = seq_pc;
        if (req.branch) begin
            redir.target = br_target;
            if (alu_done) begin
                redir.taken = cond_met;
            end else begin
                redir.wait_alu = 1'b1;  // Hold until the flags arrive
            end
        end else if (req.call) begin
            redir.target = call_addr;
            redir.taken  = 1'b1;
            redir.push   = 1'b1;
        end else if (req.ret) begin
            redir.target = ret_target;
            redir.taken  = 1'b1;
            redir.pop    = 1'b1;
        end
    end

    // A redirect is never applied while the sequencer is told to hold
    always_comb begin
        assert (!(redir.taken && redir.wait_alu))
            else $error("pc_update: taken and wait_alu set together");
    end

endmodule

// ==== return_stack.sv ====
// Return address stack, a LIFO of call return points with a sticky fault flag
`timescale 1ns/100ps
`include "pc_settings.svh"

module return_stack (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 push_en,
    input  logic                 pop_en,
    input  logic [`PC_WIDTH-1:0] push_addr,
    output logic [`PC_WIDTH-1:0] top,
    output logic                 empty,
    output logic                 fault
);

    localparam int PTR_W = $clog2(`RAS_DEPTH);
    localparam logic [PTR_W:0] DEPTH = `RAS_DEPTH;

    logic [`PC_WIDTH-1:0] entries [`RAS_DEPTH];
    logic [PTR_W:0]       count;    // Valid entries
    logic [PTR_W-1:0]     wr_idx;
    logic [PTR_W-1:0]     top_idx;
    logic                 full;

    assign wr_idx  = count[PTR_W-1:0];
    assign top_idx = wr_idx - 1'b1;  // Entry below the count, wraps correctly when full
    assign empty   = (count == '0);
    assign full    = (count == DEPTH);
    assign top     = entries[top_idx];

    // Count and fault
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
            fault <= 1'b0;
        end else if (push_en) begin
            if (full) begin
                fault <= 1'b1;  // Overflow, return point lost
            end else begin
                count <= count + 1'b1;
            end
        end else if (pop_en) begin
            if (empty) begin
                fault <= 1'b1;  // Underflow
            end else begin
                count <= count - 1'b1;
            end
        end
    end

    // Entry storage
    always_ff @(posedge clk) begin
        if (push_en && !full) begin
            entries[wr_idx] <= push_addr;
        end
    end

    // Resolver priority keeps call and return apart
    a_no_push_pop: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(push_en && pop_en)
    ) else $error("return_stack: push and pop in the same cycle");

    a_count_bound: assert property (
        @(posedge clk) disable iff (!rst_n)
        count <= DEPTH
    ) else $error("return_stack: count %0d above depth", count);

endmodule

// ==== pc_sequencer.sv ====
// Program counter register that steps, redirects or stalls and gates the stack operations
`timescale 1ns/100ps
`include "pc_settings.svh"

module pc_sequencer import pc_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 fetch_en,
    input  pc_redirect_t         redir,
    output logic [`PC_WIDTH-1:0] pc,
    output logic                 push_en,
    output logic                 pop_en,
    output logic [`PC_WIDTH-1:0] ret_addr,
    output logic                 update_done
);

    localparam logic [`PC_WIDTH-1:0] INSN_BYTES = 2;

    logic                 advance;   // PC moves this edge
    logic [`PC_WIDTH-1:0] pc_next;

    // Return point of a call, doubles as the sequential step
    assign ret_addr = pc + INSN_BYTES;

    // Stalled by the pipeline or by flags still in flight
    assign advance = fetch_en & ~redir.wait_alu;

    assign pc_next = redir.taken ? redir.target : ret_addr;

    // Stack only moves when the pipeline does
    assign push_en = fetch_en & redir.push;
    assign pop_en  = fetch_en & redir.pop;

    // Tells hazard control the redirect went through
    assign update_done = fetch_en & redir.taken;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= `RESET_VECTOR;
        end else if (advance) begin
            pc <= pc_next;
        end
    end

    // Every target from resolver or stack keeps instruction alignment
    a_pc_even: assert property (
        @(posedge clk) disable iff (!rst_n)
        !pc[0]
    ) else $error("pc_sequencer: odd pc %h", pc);

endmodule

// ==== pc_unit_top.sv ====
// Next-PC unit top joining the sequencer, branch resolver and return stack
`timescale 1ns/100ps
`include "pc_settings.svh"

module pc_unit_top import pc_pkg::*; (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 fetch_en,
    input  pc_req_t              req,
    input  alu_flags_t           flags,
    input  logic                 alu_done,
    output logic [`PC_WIDTH-1:0] pc,
    output logic                 update_done,
    output logic                 stack_fault
);

    pc_redirect_t         redir;
    logic                 push_en;
    logic                 pop_en;
    logic [`PC_WIDTH-1:0] ret_addr;   // pc + 2 to push on a call
    logic [`PC_WIDTH-1:0] ras_top;
    logic                 ras_empty;

    pc_sequencer i_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_en    (fetch_en),
        .redir       (redir),
        .pc          (pc),
        .push_en     (push_en),
        .pop_en      (pop_en),
        .ret_addr    (ret_addr),
        .update_done (update_done)
    );

    pc_update i_update (
        .pc        (pc),
        .req       (req),
        .flags     (flags),
        .alu_done  (alu_done),
        .ras_top   (ras_top),
        .ras_empty (ras_empty),
        .redir     (redir)
    );

    return_stack i_stack (
        .clk       (clk),
        .rst_n     (rst_n),
        .push_en   (push_en),
        .pop_en    (pop_en),
        .push_addr (ret_addr),
        .top       (ras_top),
        .empty     (ras_empty),
        .fault     (stack_fault)
    );

endmodule

// ==== tb_pc_unit.sv ====
// Table-driven testbench for the next-PC unit checked against a reference model
`timescale 1ns/100ps
`include "pc_settings.svh"

module tb_pc_unit import pc_pkg::*; ();

    localparam int IDX_W = $clog2(`RAS_DEPTH);
    localparam int N_RANDOM = 24;
    localparam logic [`PC_WIDTH-1:0] RST_PC = `RESET_VECTOR;
    localparam pc_req_t NO_REQ = '0;

    // One table row applied for one clock
    typedef struct packed {
        logic       rst_n;
        logic       fetch_en;
        pc_req_t    req;
        alu_flags_t flags;
        logic       alu_done;
    } stim_t;

    logic                 clk;
    logic                 rst_n;
    logic                 fetch_en;
    pc_req_t              req;
    alu_flags_t           flags;
    logic                 alu_done;
    logic [`PC_WIDTH-1:0] pc;
    logic                 update_done;
    logic                 stack_fault;

    stim_t stim_q[$];
    string name_q[$];

    // Reference model state
    logic [`PC_WIDTH-1:0] m_pc;
    logic [`PC_WIDTH-1:0] m_stack [`RAS_DEPTH];
    logic [IDX_W:0]       m_count;
    logic                 m_fault;

    int errors;
    int checks;
    int cycles = 0;
    int cycle_limit = 100000;  // Replaced once the table is built

    pc_unit_top i_dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_en    (fetch_en),
        .req         (req),
        .flags       (flags),
        .alu_done    (alu_done),
        .pc          (pc),
        .update_done (update_done),
        .stack_fault (stack_fault)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Guard against a run that never ends
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("ERROR: run did not finish within %0d cycles", cycle_limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    function automatic pc_req_t branch_req(input branch_cond_e cond,
                                           input logic [`PC_WIDTH-1:0] offset);
        pc_req_t r;
        r        = '0;
        r.branch = 1'b1;
        r.cond   = cond;
        r.offset = offset;
        return r;
    endfunction

    function automatic pc_req_t call_req(input logic [`CALL_FIELD_WIDTH-1:0] target);
        pc_req_t r;
        r             = '0;
        r.call        = 1'b1;
        r.call_target = target;
        return r;
    endfunction

    function automatic pc_req_t ret_req();
        pc_req_t r;
        r     = '0;
        r.ret = 1'b1;
        return r;
    endfunction

    // Condition table written out flag by flag
    function automatic logic cond_holds(input branch_cond_e cond, input alu_flags_t f);
        logic hit;
        hit = 1'b0;
        if (cond == EQ && f.z) hit = 1'b1;
        if (cond == LT && f.n && !f.v) hit = 1'b1;
        if (cond == GT && !f.n && !f.v && !f.z) hit = 1'b1;
        if (cond == OV && f.v) hit = 1'b1;
        if (cond == NE && !f.z) hit = 1'b1;
        if (cond == GE && (f.v || !f.n)) hit = 1'b1;
        if (cond == LE && (f.z || (f.n && !f.v))) hit = 1'b1;
        if (cond == ALWAYS) hit = 1'b1;
        return hit;
    endfunction

    function automatic logic expect_taken(input stim_t s);
        if (s.req.branch) begin
            return s.alu_done && cond_holds(s.req.cond, s.flags);
        end
        return s.req.call || s.req.ret;
    endfunction

    task automatic add_entry(input string name, input logic rst_v, input logic en,
                             input pc_req_t r, input alu_flags_t f, input logic done);
        stim_q.push_back('{rst_n: rst_v, fetch_en: en, req: r, flags: f, alu_done: done});
        name_q.push_back(name);
    endtask

    // Advance the reference model across one clock edge
    task automatic step_model(input stim_t s);
        if (!s.rst_n) begin
            m_pc    = RST_PC;
            m_count = '0;
            m_fault = 1'b0;
        end else if (s.fetch_en) begin
            if (s.req.branch) begin
                if (s.alu_done) begin
                    m_pc = cond_holds(s.req.cond, s.flags) ?
                           m_pc + 16'd2 + s.req.offset : m_pc + 16'd2;
                end
            end else if (s.req.call) begin
                if (m_count == `RAS_DEPTH) begin
                    m_fault = 1'b1;  // Overflow drops the return point
                end else begin
                    m_stack[m_count[IDX_W-1:0]] = m_pc + 16'd2;
                    m_count = m_count + 1'b1;
                end
                m_pc = {m_pc[`PC_WIDTH-1:`CALL_FIELD_WIDTH], s.req.call_target};
            end else if (s.req.ret) begin
                if (m_count == 0) begin
                    m_fault = 1'b1;
                    m_pc    = RST_PC;
                end else begin
                    m_count = m_count - 1'b1;
                    m_pc    = m_stack[m_count[IDX_W-1:0]];
                end
            end else begin
                m_pc = m_pc + 16'd2;
            end
        end
    endtask

    task automatic build_table();
        branch_cond_e         c;
        alu_flags_t           f;
        logic [`PC_WIDTH-1:0] off;
        repeat (4) add_entry("step", 1'b1, 1'b1, NO_REQ, '0, 1'b0);
        // Every condition against every flag combination
        for (int ci = 0; ci < 8; ci++) begin
            for (int fi = 0; fi < 8; fi++) begin
                c   = branch_cond_e'(3'(ci));
                f   = alu_flags_t'(3'(fi));
                off = fi[0] ? 16'hffec : 16'h0024;  // -20 or +36
                add_entry($sformatf("cond_%s_flags%0d", c.name(), fi), 1'b1, 1'b1,
                          branch_req(c, off), f, 1'b1);
            end
        end
        for (int i = 0; i < N_RANDOM; i++) begin
            c   = branch_cond_e'(3'($urandom % 8));
            f   = alu_flags_t'(3'($urandom % 8));
            off = 16'(($urandom % 256) * 2) - 16'd256;
            add_entry("random_branch", 1'b1, 1'b1, branch_req(c, off), f, 1'b1);
        end
        // Flags arrive late with z set so EQ resolves taken
        add_entry("wait_alu", 1'b1, 1'b1, branch_req(EQ, 16'h0040), 3'b100, 1'b0);
        add_entry("wait_alu", 1'b1, 1'b1, branch_req(EQ, 16'h0040), 3'b100, 1'b0);
        add_entry("alu_ready", 1'b1, 1'b1, branch_req(EQ, 16'h0040), 3'b100, 1'b1);
        add_entry("page_jump", 1'b1, 1'b1, branch_req(ALWAYS, 16'h2000), '0, 1'b1);
        add_entry("call_single", 1'b1, 1'b1, call_req(12'h120), '0, 1'b0);
        add_entry("step", 1'b1, 1'b1, NO_REQ, '0, 1'b0);
        add_entry("ret_single", 1'b1, 1'b1, ret_req(), '0, 1'b0);
        add_entry("call_outer", 1'b1, 1'b1, call_req(12'h200), '0, 1'b0);
        add_entry("step", 1'b1, 1'b1, NO_REQ, '0, 1'b0);
        add_entry("call_mid", 1'b1, 1'b1, call_req(12'h300), '0, 1'b0);
        add_entry("call_inner", 1'b1, 1'b1, call_req(12'h400), '0, 1'b0);
        add_entry("ret_inner", 1'b1, 1'b1, ret_req(), '0, 1'b0);
        add_entry("ret_mid", 1'b1, 1'b1, ret_req(), '0, 1'b0);
        add_entry("ret_outer", 1'b1, 1'b1, ret_req(), '0, 1'b0);
        // Stalled call and return must leave pc and stack alone
        add_entry("call_before_stall", 1'b1, 1'b1, call_req(12'h500), '0, 1'b0);
        add_entry("stall_call", 1'b1, 1'b0, call_req(12'h600), '0, 1'b0);
        add_entry("stall_ret", 1'b1, 1'b0, ret_req(), '0, 1'b0);
        add_entry("ret_after_stall", 1'b1, 1'b1, ret_req(), '0, 1'b0);
        add_entry("reset_mid", 1'b0, 1'b0, NO_REQ, '0, 1'b0);
        for (int i = 0; i <= `RAS_DEPTH; i++) begin
            add_entry("call_overflow", 1'b1, 1'b1, call_req(12'h010), '0, 1'b0);
        end
        add_entry("reset_mid", 1'b0, 1'b0, NO_REQ, '0, 1'b0);
        add_entry("ret_empty", 1'b1, 1'b1, ret_req(), '0, 1'b0);
        add_entry("step", 1'b1, 1'b1, NO_REQ, '0, 1'b0);
        add_entry("step", 1'b1, 1'b1, NO_REQ, '0, 1'b0);
    endtask

    initial begin
        stim_t s;
        string prev_name;
        logic  exp_done;
        void'($urandom(28));
        rst_n     = 1'b0;
        fetch_en  = 1'b0;
        req       = NO_REQ;
        flags     = '0;
        alu_done  = 1'b0;
        errors    = 0;
        checks    = 0;
        m_pc      = RST_PC;
        m_count   = '0;
        m_fault   = 1'b0;
        prev_name = "reset";
        build_table();
        cycle_limit = stim_q.size() + 20;

        repeat (2) @(posedge clk);
        foreach (stim_q[i]) begin
            s = stim_q[i];
            rst_n    <= s.rst_n;
            fetch_en <= s.fetch_en;
            req      <= s.req;
            flags    <= s.flags;
            alu_done <= s.alu_done;
            @(negedge clk);
            // pc and fault lag one row behind update_done
            exp_done = s.fetch_en && expect_taken(s);
            if (pc !== m_pc) begin
                $display("MISMATCH %s pc: expected %h, actual %h", prev_name, m_pc, pc);
                errors++;
            end
            if (stack_fault !== m_fault) begin
                $display("MISMATCH %s stack_fault: expected %b, actual %b",
                         prev_name, m_fault, stack_fault);
                errors++;
            end
            if (update_done !== exp_done) begin
                $display("MISMATCH %s update_done: expected %b, actual %b",
                         name_q[i], exp_done, update_done);
                errors++;
            end
            checks += 3;
            step_model(s);
            prev_name = name_q[i];
            @(posedge clk);
        end

        fetch_en <= 1'b0;
        req      <= NO_REQ;
        alu_done <= 1'b0;
        @(negedge clk);
        if (pc !== m_pc) begin
            $display("MISMATCH %s pc: expected %h, actual %h", prev_name, m_pc, pc);
            errors++;
        end
        if (stack_fault !== m_fault) begin
            $display("MISMATCH %s stack_fault: expected %b, actual %b",
                     prev_name, m_fault, stack_fault);
            errors++;
        end
        checks += 2;

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+.
pc_pkg.sv
pc_update.sv
return_stack.sv
pc_sequencer.sv
pc_unit_top.sv
tb_pc_unit.sv

// ==== Makefile ====
# Verilator simulation of the next-PC unit

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_pc_unit
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

# Build, run, then decide the result from the log
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
